// ==== sources.f ====
source/cache_pkg.sv
source/cache_ways.sv
source/avalon_master.sv
source/cache_ctrl.sv
source/cache_top.sv
tests/avalon_mem_model.sv
tests/tb_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and judge the run from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_cache \
  -f sources.f -o sim_cache \
  && ./obj_dir/sim_cache > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported a failure"; exit 1; } \
  || echo "Simulation passed"

// ==== tests/tb_cache.sv ====
`timescale 1ns/100ps

module tb_cache
  import cache_pkg::*;
();

  localparam int SET_BITS    = 6;
  localparam int MEM_WORDS   = 1024;
  localparam int IDX_BITS    = $clog2(MEM_WORDS);
  localparam int REQ_TIMEOUT = 200;
  localparam logic [31:0] SEED = 32'hdd9942a6;

  logic     cpu_write;
  logic     rst_n;
  logic     cpu_load;
  logic     cpu_store;
  addr_t    cpu_address;
  word_t    cpu_writedata;
  byte_en_t cpu_byteenable;
  logic     cpu_wait;
  word_t    cpu_readdata;

  addr_t    address;
  logic     read;
  logic     write;
  word_t    writedata;
  byte_en_t byteenable;
  logic     waitrequest;
  word_t    readdata;

  int       read_count;
  int       write_count;
  addr_t    last_write_address;
  word_t    last_write_data;
  byte_en_t last_write_byteenable;
  byte_en_t last_read_byteenable;

  // The expected memory contents are tracked separately from the model
  word_t       shadow [MEM_WORDS];
  logic [31:0] rand_state;
  int          errors;
  int          timeouts;

  cache_top #(
    .SET_BITS(SET_BITS)
  ) i_dut (
    .cpu_write     (cpu_write),
    .rst_n         (rst_n),
    .cpu_load      (cpu_load),
    .cpu_store     (cpu_store),
    .cpu_address   (cpu_address),
    .cpu_writedata (cpu_writedata),
    .cpu_byteenable(cpu_byteenable),
    .cpu_wait      (cpu_wait),
    .cpu_readdata  (cpu_readdata),
    .address       (address),
    .read          (read),
    .write         (write),
    .writedata     (writedata),
    .byteenable    (byteenable),
    .waitrequest   (waitrequest),
    .readdata      (readdata)
  );

  avalon_mem_model #(
    .MEM_WORDS(MEM_WORDS)
  ) i_memory (
    .cpu_write            (cpu_write),
    .rst_n                (rst_n),
    .address              (address),
    .read                 (read),
    .write                (write),
    .writedata            (writedata),
    .byteenable           (byteenable),
    .waitrequest          (waitrequest),
    .readdata             (readdata),
    .read_count           (read_count),
    .write_count          (write_count),
    .last_write_address   (last_write_address),
    .last_write_data      (last_write_data),
    .last_write_byteenable(last_write_byteenable),
    .last_read_byteenable (last_read_byteenable)
  );

  // 20 ns clock
  initial begin
    cpu_write = 1'b0;
    forever #10 cpu_write = ~cpu_write;
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int slot_of(input addr_t addr);
    return int'(addr[IDX_BITS+1:2]);
  endfunction

  // Enabled lanes take the new bytes and the rest keep the old ones
  function automatic word_t merge_lanes(input word_t old_word, input word_t new_word,
                                        input byte_en_t lanes);
    word_t result;
    for (int b = 0; b < $bits(byte_en_t); b++) begin
      result[8*b +: 8] = lanes[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return result;
  endfunction

  function automatic word_t expected_word(input addr_t addr);
    return shadow[slot_of(addr)];
  endfunction

  task automatic record_store(input addr_t addr, input word_t data, input byte_en_t lanes);
    shadow[slot_of(addr)] = merge_lanes(shadow[slot_of(addr)], data, lanes);
  endtask

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic match_address(input string name, input addr_t expected, input addr_t actual);
    if (expected !== actual) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_byte_en(input string name, input byte_en_t expected,
                               input byte_en_t actual);
    if (expected !== actual) begin
      errors++;
      $display("error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic verify_count(input string name, input int expected, input int actual);
    if (expected != actual) begin
      errors++;
      $display("error %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic expect_level(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      errors++;
      $display("error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Runs one CPU request that starts and ends on a falling edge
  // wait_cycles counts the falling edges at which cpu_wait was still high
  task automatic cpu_access(input string name, input logic is_store, input addr_t addr,
                            input word_t data, input byte_en_t lanes,
                            output word_t rdata, output int wait_cycles);
    int   cycles;
    logic completed;
    cycles         = 0;
    completed      = 1'b0;
    rdata          = '0;
    cpu_address    = addr;
    cpu_writedata  = data;
    cpu_byteenable = lanes;
    cpu_load       = !is_store;
    cpu_store      = is_store;
    while (!completed && cycles < REQ_TIMEOUT) begin
      @(negedge cpu_write);
      if (cpu_wait) begin
        cycles++;
      end else begin
        completed = 1'b1;
      end
    end
    if (completed) begin
      // Read data is valid in the cycle whose rising edge completes the request
      rdata = cpu_readdata;
      @(negedge cpu_write);
    end else begin
      timeouts++;
      $display("%s: request never completed", name);
    end
    cpu_load    = 1'b0;
    cpu_store   = 1'b0;
    wait_cycles = cycles;
  endtask

  task automatic idle_after_reset();
    expect_level("reset cpu_wait", 1'b0, cpu_wait);
    expect_level("reset read", 1'b0, read);
    expect_level("reset write", 1'b0, write);
  endtask

  task automatic load_miss_then_hit();
    addr_t addr;
    word_t got;
    int    cycles;
    int    reads_before;
    addr         = 32'h0000_0104;
    reads_before = read_count;
    cpu_access("load miss", 1'b0, addr, '0, '0, got, cycles);
    compare_word("load miss data", expected_word(addr), got);
    verify_count("load miss reads", reads_before + 1, read_count);
    // A fill fetches the whole word whatever lanes the load carried
    check_byte_en("load miss read lanes", 4'b1111, last_read_byteenable);
    cpu_access("load hit", 1'b0, addr, '0, '0, got, cycles);
    compare_word("load hit data", expected_word(addr), got);
    verify_count("load hit reads", reads_before + 1, read_count);
    // A hit stalls the CPU for the lookup cycle only
    verify_count("load hit wait cycles", 1, cycles);
  endtask

  task automatic write_through_hit();
    addr_t    addr;
    word_t    data;
    byte_en_t lanes;
    word_t    got;
    int       cycles;
    int       reads_before;
    int       writes_before;
    // The address sits at byte offset 1, which the bus address must drop
    addr  = 32'h0000_0209;
    data  = 32'hcafe_f00d;
    lanes = 4'b0101;
    cpu_access("store hit fill", 1'b0, addr, '0, '0, got, cycles);
    compare_word("store hit fill data", expected_word(addr), got);
    reads_before  = read_count;
    writes_before = write_count;
    cpu_access("store hit", 1'b1, addr, data, lanes, got, cycles);
    record_store(addr, data, lanes);
    verify_count("store hit writes", writes_before + 1, write_count);
    verify_count("store hit reads", reads_before, read_count);
    match_address("store hit address", {addr[31:2], 2'b00}, last_write_address);
    compare_word("store hit bus data", data, last_write_data);
    check_byte_en("store hit lanes", lanes, last_write_byteenable);
    cpu_access("store hit reload", 1'b0, addr, '0, '0, got, cycles);
    compare_word("store hit reload data", expected_word(addr), got);
    verify_count("store hit reload reads", reads_before, read_count);
  endtask

  task automatic no_allocate_miss();
    addr_t    addr;
    word_t    data;
    byte_en_t lanes;
    word_t    got;
    int       cycles;
    int       reads_before;
    int       writes_before;
    addr          = 32'h0000_030c;
    data          = 32'h1234_5678;
    lanes         = 4'b1100;
    reads_before  = read_count;
    writes_before = write_count;
    cpu_access("store miss", 1'b1, addr, data, lanes, got, cycles);
    record_store(addr, data, lanes);
    verify_count("store miss writes", writes_before + 1, write_count);
    verify_count("store miss reads", reads_before, read_count);
    check_byte_en("store miss lanes", lanes, last_write_byteenable);
    // Nothing was allocated, so this load has to go to the bus
    cpu_access("store miss reload", 1'b0, addr, '0, '0, got, cycles);
    compare_word("store miss reload data", expected_word(addr), got);
    verify_count("store miss reload reads", reads_before + 1, read_count);
  endtask

  task automatic replacement_order();
    addr_t addr;
    word_t got;
    int    cycles;
    int    reads_before;
    // Tags 1 to 5 all map to set 5
    for (int t = 1; t <= 5; t++) begin
      addr = (addr_t'(t) << 8) | 32'h14;
      cpu_access("replace fill", 1'b0, addr, '0, '0, got, cycles);
      compare_word("replace fill data", expected_word(addr), got);
    end
    reads_before = read_count;
    for (int t = 2; t <= 5; t++) begin
      addr = (addr_t'(t) << 8) | 32'h14;
      cpu_access("replace keep", 1'b0, addr, '0, '0, got, cycles);
      compare_word("replace keep data", expected_word(addr), got);
    end
    verify_count("replace keep reads", reads_before, read_count);
    // Tag 1 was pushed out of way 3 by the fifth fill
    addr = 32'h0000_0114;
    cpu_access("replace evicted", 1'b0, addr, '0, '0, got, cycles);
    compare_word("replace evicted data", expected_word(addr), got);
    verify_count("replace evicted reads", reads_before + 1, read_count);
  endtask

  task automatic random_traffic();
    addr_t    addr;
    word_t    data;
    byte_en_t lanes;
    word_t    got;
    int       cycles;
    int       writes_before;
    logic     is_store;
    for (int n = 0; n < 100; n++) begin
      // The mask keeps four sets and sixteen tags so ways get evicted often
      rand_state = next_random(rand_state);
      addr       = rand_state & 32'h0000_0f0f;
      is_store   = rand_state[16];
      lanes      = rand_state[23:20];
      rand_state = next_random(rand_state);
      data       = rand_state;
      writes_before = write_count;
      cpu_access("random", is_store, addr, data, lanes, got, cycles);
      if (is_store) begin
        record_store(addr, data, lanes);
        verify_count("random store writes", writes_before + 1, write_count);
      end else begin
        compare_word("random load data", expected_word(addr), got);
      end
    end
  endtask

  initial begin
    errors         = 0;
    timeouts       = 0;
    rand_state     = SEED;
    rst_n          = 1'b0;
    cpu_load       = 1'b0;
    cpu_store      = 1'b0;
    cpu_address    = '0;
    cpu_writedata  = '0;
    cpu_byteenable = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = 32'(i) ^ 32'h5a5a0000;
    end
    repeat (4) @(negedge cpu_write);
    rst_n = 1'b1;
    idle_after_reset();
    load_miss_then_hit();
    write_through_hit();
    no_allocate_miss();
    replacement_order();
    random_traffic();
    $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tests/avalon_mem_model.sv ====
`timescale 1ns/100ps

module avalon_mem_model
  import cache_pkg::*;
#(
  parameter int MEM_WORDS = 1024
) (
  input  logic     cpu_write,
  input  logic     rst_n,
  input  addr_t    address,
  input  logic     read,
  input  logic     write,
  input  word_t    writedata,
  input  byte_en_t byteenable,
  output logic     waitrequest,
  output word_t    readdata,
  output int       read_count,
  output int       write_count,
  output addr_t    last_write_address,
  output word_t    last_write_data,
  output byte_en_t last_write_byteenable,
  output byte_en_t last_read_byteenable
);

  localparam int IDX_BITS = $clog2(MEM_WORDS);
  localparam logic [31:0] SEED = 32'hdd9942a6;

  word_t               mem [MEM_WORDS];
  logic [IDX_BITS-1:0] word_index;
  logic [31:0]         rand_state;
  logic [1:0]          wait_target;
  logic [1:0]          wait_cnt;
  logic                active;

  // Each xorshift step yields the next wait-state draw
  function automatic logic [31:0] xorshift_next(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  assign active     = read | write;
  assign word_index = address[IDX_BITS+1:2];

  // Read data follows the held address, so it is ready whenever waitrequest drops
  assign readdata = mem[word_index];

  // A transfer is stalled until it has spent wait_target cycles on the bus
  // A target of zero lets it complete in its first cycle
  assign waitrequest = active && (wait_cnt != wait_target);

  always @(posedge cpu_write or negedge rst_n) begin
    if (!rst_n) begin
      // Untouched words read back as their word address XOR a fixed mark
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= 32'(i) ^ 32'h5a5a0000;
      end
      rand_state            <= xorshift_next(SEED);
      wait_target           <= SEED[1:0];
      wait_cnt              <= '0;
      read_count            <= 0;
      write_count           <= 0;
      last_write_address    <= '0;
      last_write_data       <= '0;
      last_write_byteenable <= '0;
      last_read_byteenable  <= '0;
    end else if (active && !waitrequest) begin
      if (write) begin
        // Only the enabled lanes change
        for (int b = 0; b < $bits(byte_en_t); b++) begin
          if (byteenable[b]) begin
            mem[word_index][8*b +: 8] <= writedata[8*b +: 8];
          end
        end
        write_count           <= write_count + 1;
        last_write_address    <= address;
        last_write_data       <= writedata;
        last_write_byteenable <= byteenable;
      end else begin
        read_count           <= read_count + 1;
        last_read_byteenable <= byteenable;
      end
      // Draw the stall length of the next transfer
      rand_state  <= xorshift_next(rand_state);
      wait_target <= rand_state[1:0];
      wait_cnt    <= '0;
    end else if (active) begin
      wait_cnt <= wait_cnt + 2'd1;
    end
  end

endmodule

// ==== source/cache_top.sv ====
`timescale 1ns/100ps

module cache_top
  import cache_pkg::*;
#(
  parameter int SET_BITS = 6
) (
  input  logic     cpu_write,
  input  logic     rst_n,

  // CPU side
  input  logic     cpu_load,
  input  logic     cpu_store,
  input  addr_t    cpu_address,
  input  word_t    cpu_writedata,
  input  byte_en_t cpu_byteenable,
  output logic     cpu_wait,
  output word_t    cpu_readdata,

  // Avalon side
  output addr_t    address,
  output logic     read,
  output logic     write,
  output word_t    writedata,
  output byte_en_t byteenable,
  input  logic     waitrequest,
  input  word_t    readdata
);

  // Controller to way array
  addr_t    lookup_address;
  logic     fill;
  word_t    fill_data;
  logic     update;
  word_t    update_data;
  byte_en_t update_byteenable;
  logic     hit;
  word_t    hit_data;

  // Controller to bus master
  logic     start_read;
  logic     start_write;
  addr_t    bus_address_in;
  word_t    bus_writedata_in;
  byte_en_t bus_byteenable_in;
  logic     bus_done;
  word_t    bus_data;

  // Tag store and data, looked up in parallel with whatever the bus is doing
  cache_ways #(
    .SET_BITS(SET_BITS)
  ) i_cache_ways (
    .cpu_write        (cpu_write),
    .rst_n            (rst_n),
    .lookup_address   (lookup_address),
    .fill             (fill),
    .fill_data        (fill_data),
    .update           (update),
    .update_data      (update_data),
    .update_byteenable(update_byteenable),
    .hit              (hit),
    .hit_data         (hit_data)
  );

  // Single outstanding Avalon transfer
  avalon_master i_avalon_master (
    .cpu_write        (cpu_write),
    .rst_n            (rst_n),
    .start_read       (start_read),
    .start_write      (start_write),
    .bus_address_in   (bus_address_in),
    .bus_writedata_in (bus_writedata_in),
    .bus_byteenable_in(bus_byteenable_in),
    .bus_done         (bus_done),
    .bus_data         (bus_data),
    .address          (address),
    .read             (read),
    .write            (write),
    .writedata        (writedata),
    .byteenable       (byteenable),
    .waitrequest      (waitrequest),
    .readdata         (readdata)
  );

  // Sequencing of lookups, bus transfers, fills and store merges
  cache_ctrl i_cache_ctrl (
    .cpu_write        (cpu_write),
    .rst_n            (rst_n),
    .cpu_load         (cpu_load),
    .cpu_store        (cpu_store),
    .cpu_address      (cpu_address),
    .cpu_writedata    (cpu_writedata),
    .cpu_byteenable   (cpu_byteenable),
    .cpu_wait         (cpu_wait),
    .cpu_readdata     (cpu_readdata),
    .hit              (hit),
    .hit_data         (hit_data),
    .bus_done         (bus_done),
    .bus_data         (bus_data),
    .lookup_address   (lookup_address),
    .fill             (fill),
    .fill_data        (fill_data),
    .update           (update),
    .update_data      (update_data),
    .update_byteenable(update_byteenable),
    .start_read       (start_read),
    .start_write      (start_write),
    .bus_address_in   (bus_address_in),
    .bus_writedata_in (bus_writedata_in),
    .bus_byteenable_in(bus_byteenable_in)
  );

endmodule

// ==== source/cache_ctrl.sv ====
`timescale 1ns/100ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic     cpu_write,
  input  logic     rst_n,
  input  logic     cpu_load,
  input  logic     cpu_store,
  input  addr_t    cpu_address,
  input  word_t    cpu_writedata,
  input  byte_en_t cpu_byteenable,
  output logic     cpu_wait,
  output word_t    cpu_readdata,
  input  logic     hit,
  input  word_t    hit_data,
  input  logic     bus_done,
  input  word_t    bus_data,
  output addr_t    lookup_address,
  output logic     fill,
  output word_t    fill_data,
  output logic     update,
  output word_t    update_data,
  output byte_en_t update_byteenable,
  output logic     start_read,
  output logic     start_write,
  output addr_t    bus_address_in,
  output word_t    bus_writedata_in,
  output byte_en_t bus_byteenable_in
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  // Request kind, kept from idle until the request is finished
  logic req_store_q;

  // Set for the one cycle of done that follows a fill state
  logic from_fill_q;

  // Copy of the CPU request taken in idle
  addr_t    req_address_q;
  word_t    req_writedata_q;
  byte_en_t req_byteenable_q;

  logic request;

  assign request = cpu_load | cpu_store;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_idle: begin
        if (request) begin
          state_d = ctrl_lookup;
        end
      end
      ctrl_lookup: begin
        // Stores always go to the bus, loads only when the tag missed
        if (req_store_q) begin
          state_d = ctrl_bus_write;
        end else if (hit) begin
          state_d = ctrl_done;
        end else begin
          state_d = ctrl_bus_read;
        end
      end
      ctrl_bus_read: begin
        if (bus_done) begin
          state_d = ctrl_fill;
        end
      end
      ctrl_fill: begin
        state_d = ctrl_done;
      end
      ctrl_bus_write: begin
        if (bus_done) begin
          state_d = ctrl_done;
        end
      end
      ctrl_done: begin
        // The CPU request completes at the edge leaving this state
        state_d = ctrl_idle;
      end
      default: begin
        state_d = ctrl_idle;
      end
    endcase
  end

  always_ff @(posedge cpu_write or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ctrl_idle;
      req_store_q <= 1'b0;
      from_fill_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      from_fill_q <= (state_q == ctrl_fill);
      if (state_q == ctrl_idle && request) begin
        req_store_q <= cpu_store;
      end
    end
  end

  // Request payload and the data going back to the CPU
  always_ff @(posedge cpu_write) begin
    if (state_q == ctrl_idle && request) begin
      req_address_q    <= cpu_address;
      req_writedata_q  <= cpu_writedata;
      req_byteenable_q <= cpu_byteenable;
    end
    if (state_q == ctrl_lookup && !req_store_q && hit) begin
      cpu_readdata <= hit_data;
    end else if (state_q == ctrl_fill) begin
      cpu_readdata <= bus_data;
    end
  end

  // Wait is combinational so the CPU is held from the very cycle its request rises
  assign cpu_wait = request && (state_q != ctrl_done);

  // The way array always looks at the held request address
  assign lookup_address = req_address_q;

  // Fill lands at the edge that hands the word to the CPU
  assign fill      = (state_q == ctrl_done) && from_fill_q;
  assign fill_data = cpu_readdata;

  // Store hits are merged as the bus write finishes
  // The way array ignores the strobe when nothing matches
  assign update            = (state_q == ctrl_bus_write) && bus_done;
  assign update_data       = req_writedata_q;
  assign update_byteenable = req_byteenable_q;

  // Start pulses last the single lookup cycle
  assign start_read  = (state_q == ctrl_lookup) && !req_store_q && !hit;
  assign start_write = (state_q == ctrl_lookup) && req_store_q;

  // Reads always fetch the whole word, writes carry the CPU lanes
  assign bus_address_in    = req_address_q;
  assign bus_writedata_in  = req_writedata_q;
  assign bus_byteenable_in = req_store_q ? req_byteenable_q : '1;

endmodule

// ==== source/avalon_master.sv ====
`timescale 1ns/100ps

module avalon_master
  import cache_pkg::*;
(
  input  logic     cpu_write,
  input  logic     rst_n,
  input  logic     start_read,
  input  logic     start_write,
  input  addr_t    bus_address_in,
  input  word_t    bus_writedata_in,
  input  byte_en_t bus_byteenable_in,
  output logic     bus_done,
  output word_t    bus_data,
  output addr_t    address,
  output logic     read,
  output logic     write,
  output word_t    writedata,
  output byte_en_t byteenable,
  input  logic     waitrequest,
  input  word_t    readdata
);

  logic busy;
  logic accept;

  // Only one transfer is ever outstanding
  assign busy   = read | write;
  assign accept = !busy && (start_read || start_write);

  // Strobes and the completion pulse
  // A strobe goes up one edge after its start pulse and comes down at the edge
  // where the slave drops waitrequest
  always_ff @(posedge cpu_write or negedge rst_n) begin
    if (!rst_n) begin
      read     <= 1'b0;
      write    <= 1'b0;
      bus_done <= 1'b0;
    end else begin
      bus_done <= 1'b0;
      if (busy) begin
        if (!waitrequest) begin
          read     <= 1'b0;
          write    <= 1'b0;
          bus_done <= 1'b1;
        end
      end else if (accept) begin
        read  <= start_read;
        write <= start_write;
      end
    end
  end

  // Address, data and lanes are latched once and stay put while waitrequest is high
  // Word aligned addresses only, so the byte offset is forced to zero
  always_ff @(posedge cpu_write) begin
    if (accept) begin
      address    <= {bus_address_in[31:2], 2'b00};
      writedata  <= bus_writedata_in;
      byteenable <= bus_byteenable_in;
    end
  end

  // Read data is only valid at the completing edge, so keep a copy for the controller
  always_ff @(posedge cpu_write) begin
    if (read && !waitrequest) begin
      bus_data <= readdata;
    end
  end

endmodule

// ==== source/cache_ways.sv ====
`timescale 1ns/100ps

module cache_ways
  import cache_pkg::*;
#(
  parameter int SET_BITS = 6
) (
  input  logic     cpu_write,
  input  logic     rst_n,
  input  addr_t    lookup_address,
  input  logic     fill,
  input  word_t    fill_data,
  input  logic     update,
  input  word_t    update_data,
  input  byte_en_t update_byteenable,
  output logic     hit,
  output word_t    hit_data
);

  // Whatever is left of the 30 word-address bits after the index is the tag
  localparam int TAG_BITS = 30 - SET_BITS;
  localparam int NUM_SETS = 1 << SET_BITS;
  localparam int WAY_BITS = $clog2(NUM_WAYS);
  localparam int NUM_LANES = $bits(byte_en_t);

  // Valid bits per set, bit w belongs to way w
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];

  // Tag and data storage, indexed by set then way
  logic [TAG_BITS-1:0] tag_q [NUM_SETS][NUM_WAYS];
  word_t               data_q [NUM_SETS][NUM_WAYS];

  logic [SET_BITS-1:0] set_index;
  logic [TAG_BITS-1:0] lookup_tag;
  logic [NUM_WAYS-1:0] way_match;
  logic [WAY_BITS-1:0] hit_way;
  word_t               merged_data;

  // Bits 1:0 are the byte offset and play no part in the lookup
  assign set_index  = lookup_address[SET_BITS+1:2];
  assign lookup_tag = lookup_address[31:SET_BITS+2];

  // All ways of the indexed set are compared at once
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_match[w] = valid_q[set_index][w] && (tag_q[set_index][w] == lookup_tag);
    end
  end

  // Encode the matching way
  // Walking down from the top lets way 0 win when a tag sits in two ways
  always_comb begin
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_match[w]) begin
        hit_way = WAY_BITS'(w);
      end
    end
  end

  assign hit      = |way_match;
  assign hit_data = data_q[set_index][hit_way];

  // New word for a store hit
  // Enabled lanes come from the store, the others keep the cached bytes
  always_comb begin
    for (int b = 0; b < NUM_LANES; b++) begin
      if (update_byteenable[b]) begin
        merged_data[8*b +: 8] = update_data[8*b +: 8];
      end else begin
        merged_data[8*b +: 8] = hit_data[8*b +: 8];
      end
    end
  end

  // Valid bits follow the same shift as the tags and data below
  // A fill always leaves way 0 valid, and the old way 3 bit falls off the end
  always_ff @(posedge cpu_write or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (fill) begin
      valid_q[set_index] <= {valid_q[set_index][NUM_WAYS-2:0], 1'b1};
    end
  end

  // Fill inserts at way 0 and pushes every other way down by one place
  // The most recently filled word therefore always sits in way 0
  always_ff @(posedge cpu_write) begin
    if (fill) begin
      for (int w = NUM_WAYS - 1; w > 0; w--) begin
        tag_q[set_index][w]  <= tag_q[set_index][w-1];
        data_q[set_index][w] <= data_q[set_index][w-1];
      end
      tag_q[set_index][0]  <= lookup_tag;
      data_q[set_index][0] <= fill_data;
    end else if (update && hit) begin
      // A store that missed leaves the set alone (no allocation on write)
      data_q[set_index][hit_way] <= merged_data;
    end
  end

endmodule

// ==== source/cache_pkg.sv ====
package cache_pkg;

  // One data word, as seen by both the CPU and the Avalon bus
  typedef logic [31:0] word_t;

  // Byte address; bits 1:0 never select anything inside the cache
  typedef logic [31:0] addr_t;

  // Bit i enables byte lane i, that is bits 8i+7 down to 8i
  typedef logic [3:0] byte_en_t;

  // Associativity of the cache
  // The insert-and-shift replacement in cache_ways is written around this value
  localparam int NUM_WAYS = 4;

  // Controller states
  // A load hit runs idle, lookup, done
  // A load miss runs idle, lookup, bus_read, fill, done
  // A store always runs idle, lookup, bus_write, done
  typedef enum logic [2:0] {
    ctrl_idle,
    ctrl_lookup,
    ctrl_bus_read,
    ctrl_fill,
    ctrl_bus_write,
    ctrl_done
  } ctrl_state_t;

endpackage
